/* common/fetch_defs.svh */
//--------------------------------------------------------------------
// width constants for the instruction fetch front end
// included by fetch_types_pkg and by any module that slices a PC
//--------------------------------------------------------------------
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and translation widths
`define FETCH_PC_WIDTH 32
`define FETCH_VPN_WIDTH 20
`define FETCH_PPN_WIDTH 20
`define FETCH_ASID_WIDTH 9

// icache geometry
`define FETCH_INDEX_WIDTH 6
`define FETCH_OFFSET_WIDTH 4

// fetch block shape, 2-byte parcels
`define FETCH_BLOCK_BYTES 16
`define FETCH_PARCELS 8

`endif

/* common/fetch_types_pkg.sv */
//--------------------------------------------------------------------
// shared vector types and the fetch state encoding
// import inside a module body, scoped names in port lists
//--------------------------------------------------------------------
`default_nettype none

`include "fetch_defs.svh"

package fetch_types_pkg;

	// address pieces
	typedef logic [`FETCH_PC_WIDTH-1:0] pc_t;
	typedef logic [`FETCH_VPN_WIDTH-1:0] vpn_t;
	typedef logic [`FETCH_PPN_WIDTH-1:0] ppn_t;
	typedef logic [`FETCH_ASID_WIDTH-1:0] asid_t;
	typedef logic [`FETCH_INDEX_WIDTH-1:0] icache_index_t;
	typedef logic [`FETCH_OFFSET_WIDTH-1:0] block_offset_t;

	// instruction payload
	typedef logic [`FETCH_BLOCK_BYTES*8-1:0] fetch_block_t;
	typedef logic [`FETCH_PARCELS-1:0] parcel_mask_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_WAIT_RESP,
		FETCH_PARKED
	} fetch_state_t;

endpackage

`default_nettype wire

/* fetch_unit/fetch_pc_gen.sv */
//--------------------------------------------------------------------
// fetch PC and ASID, fetch FSM and the ITLB/icache request issue
// requests are single-cycle pulses, one block in flight at a time
//--------------------------------------------------------------------
`default_nettype none

`include "fetch_defs.svh"

module fetch_pc_gen (
	input logic CLK,
	input logic nRST,
	input logic rob_restart_valid,
	input fetch_types_pkg::pc_t rob_restart_pc,
	input fetch_types_pkg::asid_t rob_restart_asid,
	input logic decode_restart_valid,
	input fetch_types_pkg::pc_t decode_restart_pc,
	input logic decode_trigger_wait_for_restart,
	input logic resp_accept,
	input logic resp_retry,
	output logic itlb_req_valid,
	output fetch_types_pkg::vpn_t itlb_req_vpn,
	output fetch_types_pkg::asid_t itlb_req_asid,
	output logic icache_req_valid,
	output fetch_types_pkg::icache_index_t icache_req_index,
	output fetch_types_pkg::block_offset_t icache_req_block_offset,
	output fetch_types_pkg::pc_t fetch_pc
);
	import fetch_types_pkg::*;

	fetch_state_t state;
	fetch_state_t state_next;
	pc_t pc_next;
	pc_t next_block_pc;
	asid_t asid_q;
	asid_t asid_next;
	logic req_q;
	logic req_next;

	// sequential fetch goes to the next aligned block
	assign next_block_pc = {fetch_pc[`FETCH_PC_WIDTH-1:`FETCH_OFFSET_WIDTH],
		{`FETCH_OFFSET_WIDTH{1'b0}}} + pc_t'(`FETCH_BLOCK_BYTES);

	always_comb begin
		state_next = state;
		pc_next = fetch_pc;
		asid_next = asid_q;
		req_next = 1'b0;
		// rob restart wins over decode
		if (rob_restart_valid) begin
			pc_next = rob_restart_pc;
			asid_next = rob_restart_asid;
			state_next = FETCH_WAIT_RESP;
			req_next = 1'b1;
		end else if (decode_restart_valid) begin
			pc_next = decode_restart_pc;
			state_next = FETCH_WAIT_RESP;
			req_next = 1'b1;
		end else if (decode_trigger_wait_for_restart) begin
			state_next = FETCH_PARKED;
		end else begin
			case (state)
				FETCH_IDLE, FETCH_WAIT_RESP: begin
					if (resp_accept) begin
						pc_next = next_block_pc;
						state_next = FETCH_WAIT_RESP;
						req_next = 1'b1;
					end else if (resp_retry) begin
						// miss, same block again
						state_next = FETCH_WAIT_RESP;
						req_next = 1'b1;
					end
				end
				default: begin
					// parked until the next restart
					state_next = FETCH_PARKED;
				end
			endcase
		end
	end

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			state <= FETCH_IDLE;
			fetch_pc <= '0;
			asid_q <= '0;
			req_q <= 1'b0;
		end else begin
			state <= state_next;
			fetch_pc <= pc_next;
			asid_q <= asid_next;
			req_q <= req_next;
		end
	end

	// ITLB and icache lookups go out together
	assign itlb_req_valid = req_q;
	assign icache_req_valid = req_q;
	assign itlb_req_vpn = fetch_pc[`FETCH_PC_WIDTH-1 -: `FETCH_VPN_WIDTH];
	assign itlb_req_asid = asid_q;
	assign icache_req_index = fetch_pc[`FETCH_OFFSET_WIDTH +: `FETCH_INDEX_WIDTH];
	assign icache_req_block_offset = fetch_pc[`FETCH_OFFSET_WIDTH-1:0];

endmodule

`default_nettype wire

/* fetch_unit/fetch_tag_check.sv */
//--------------------------------------------------------------------
// way tag compare against the translated page, icache hit/miss
// feedback and the registered istream entry for decode
//--------------------------------------------------------------------
`default_nettype none

`include "fetch_defs.svh"

module fetch_tag_check (
	input logic CLK,
	input logic nRST,
	input logic resp_valid,
	input fetch_types_pkg::pc_t resp_pc,
	input fetch_types_pkg::ppn_t itlb_resp_ppn,
	input logic itlb_resp_page_fault,
	input logic itlb_resp_access_fault,
	input logic [1:0] icache_resp_valid_by_way,
	input fetch_types_pkg::ppn_t [1:0] icache_resp_tag_by_way,
	input fetch_types_pkg::fetch_block_t [1:0] icache_resp_instr_by_way,
	input logic istream_stall,
	output logic icache_resp_hit_valid,
	output logic icache_resp_hit_way,
	output logic icache_resp_miss_valid,
	output fetch_types_pkg::ppn_t icache_resp_miss_tag,
	output logic istream_valid,
	output fetch_types_pkg::parcel_mask_t istream_valid_by_parcel,
	output fetch_types_pkg::fetch_block_t istream_instr_block,
	output fetch_types_pkg::pc_t istream_after_pc,
	output logic istream_page_fault,
	output logic istream_access_fault,
	output logic resp_accept,
	output logic resp_retry
);
	import fetch_types_pkg::*;

	logic [1:0] hit_by_way;
	logic any_hit;
	logic hit_way;
	logic fault;
	logic load;
	parcel_mask_t parcel_mask;
	pc_t after_pc;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit_by_way[w] = icache_resp_valid_by_way[w] &&
				(icache_resp_tag_by_way[w] == itlb_resp_ppn);
		end
	end

	assign any_hit = |hit_by_way;
	assign hit_way = hit_by_way[1];
	assign fault = itlb_resp_page_fault | itlb_resp_access_fault;
	// faults still go to decode, with a zero block
	assign load = resp_valid & (any_hit | fault);

	assign resp_accept = resp_valid & any_hit & ~fault;
	assign resp_retry = resp_valid & ~any_hit & ~fault;

	// parcels from the PC offset to the end of the block
	assign parcel_mask = {`FETCH_PARCELS{1'b1}} << resp_pc[`FETCH_OFFSET_WIDTH-1:1];
	assign after_pc = {resp_pc[`FETCH_PC_WIDTH-1:`FETCH_OFFSET_WIDTH],
		{`FETCH_OFFSET_WIDTH{1'b0}}} + pc_t'(`FETCH_BLOCK_BYTES);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			istream_valid <= 1'b0;
			icache_resp_hit_valid <= 1'b0;
			icache_resp_miss_valid <= 1'b0;
		end else begin
			// entry stays put while decode stalls
			if (load) begin
				istream_valid <= 1'b1;
			end else if (!istream_stall) begin
				istream_valid <= 1'b0;
			end
			icache_resp_hit_valid <= resp_accept;
			icache_resp_miss_valid <= resp_retry;
		end
	end

	always_ff @(posedge CLK) begin
		if (load) begin
			istream_valid_by_parcel <= parcel_mask;
			istream_instr_block <= fault ? fetch_block_t'(0) : icache_resp_instr_by_way[hit_way];
			istream_after_pc <= after_pc;
			istream_page_fault <= itlb_resp_page_fault;
			istream_access_fault <= itlb_resp_access_fault;
		end
		if (resp_valid) begin
			icache_resp_hit_way <= hit_way;
			icache_resp_miss_tag <= itlb_resp_ppn;
		end
	end

endmodule

`default_nettype wire

/* fetch_unit/fetch_unit.sv */
//--------------------------------------------------------------------
// fetch core with the in-flight request tracking, restart kill and
// the one-entry response hold used while decode stalls
//--------------------------------------------------------------------
`default_nettype none

module fetch_unit (
	input logic CLK,
	input logic nRST,
	output logic itlb_req_valid,
	output fetch_types_pkg::vpn_t itlb_req_vpn,
	output fetch_types_pkg::asid_t itlb_req_asid,
	input logic itlb_resp_valid,
	input fetch_types_pkg::ppn_t itlb_resp_ppn,
	input logic itlb_resp_page_fault,
	input logic itlb_resp_access_fault,
	output logic icache_req_valid,
	output fetch_types_pkg::icache_index_t icache_req_index,
	output fetch_types_pkg::block_offset_t icache_req_block_offset,
	input logic [1:0] icache_resp_valid_by_way,
	input fetch_types_pkg::ppn_t [1:0] icache_resp_tag_by_way,
	input fetch_types_pkg::fetch_block_t [1:0] icache_resp_instr_by_way,
	output logic icache_resp_hit_valid,
	output logic icache_resp_hit_way,
	output logic icache_resp_miss_valid,
	output fetch_types_pkg::ppn_t icache_resp_miss_tag,
	output logic istream_valid,
	output fetch_types_pkg::parcel_mask_t istream_valid_by_parcel,
	output fetch_types_pkg::fetch_block_t istream_instr_block,
	output fetch_types_pkg::pc_t istream_after_pc,
	output logic istream_page_fault,
	output logic istream_access_fault,
	input logic istream_stall,
	input logic rob_restart_valid,
	input fetch_types_pkg::pc_t rob_restart_pc,
	input fetch_types_pkg::asid_t rob_restart_asid,
	input logic decode_restart_valid,
	input fetch_types_pkg::pc_t decode_restart_pc,
	input logic decode_trigger_wait_for_restart
);
	import fetch_types_pkg::*;

	pc_t fetch_pc;
	logic resp_accept;
	logic resp_retry;
	logic kill;
	logic wait_trigger;
	logic tc_valid;
	logic tc_fault;
	logic inflight_live;
	pc_t inflight_pc;

	// response parked under stall
	logic hold_valid;
	pc_t hold_pc;
	ppn_t hold_ppn;
	logic hold_page_fault;
	logic hold_access_fault;
	logic [1:0] hold_valid_by_way;
	ppn_t [1:0] hold_tag_by_way;
	fetch_block_t [1:0] hold_instr_by_way;

	// any restart or wait request drops what is in flight
	assign kill = rob_restart_valid | decode_restart_valid | decode_trigger_wait_for_restart;
	assign tc_valid = !istream_stall && !kill &&
		(hold_valid || (itlb_resp_valid && inflight_live));
	assign tc_fault = hold_valid ? (hold_page_fault | hold_access_fault) :
		(itlb_resp_page_fault | itlb_resp_access_fault);
	// a faulting block parks fetch the same way decode does
	assign wait_trigger = decode_trigger_wait_for_restart | (tc_valid & tc_fault);

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			inflight_live <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (kill) begin
				inflight_live <= 1'b0;
			end else if (itlb_req_valid) begin
				inflight_live <= 1'b1;
			end else if (itlb_resp_valid) begin
				inflight_live <= 1'b0;
			end
			if (kill || !istream_stall) begin
				hold_valid <= 1'b0;
			end else if (itlb_resp_valid && inflight_live) begin
				hold_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (itlb_req_valid) begin
			inflight_pc <= fetch_pc;
		end
		if (itlb_resp_valid && inflight_live && istream_stall) begin
			hold_pc <= inflight_pc;
			hold_ppn <= itlb_resp_ppn;
			hold_page_fault <= itlb_resp_page_fault;
			hold_access_fault <= itlb_resp_access_fault;
			hold_valid_by_way <= icache_resp_valid_by_way;
			hold_tag_by_way <= icache_resp_tag_by_way;
			hold_instr_by_way <= icache_resp_instr_by_way;
		end
	end

	//--------------------------------------------------------------------
	// submodules

	fetch_pc_gen u_pc_gen (
		.*,
		.decode_trigger_wait_for_restart(wait_trigger)
	);

	fetch_tag_check u_tag_check (
		.*,
		.resp_valid(tc_valid),
		.resp_pc(hold_valid ? hold_pc : inflight_pc),
		.itlb_resp_ppn(hold_valid ? hold_ppn : itlb_resp_ppn),
		.itlb_resp_page_fault(hold_valid ? hold_page_fault : itlb_resp_page_fault),
		.itlb_resp_access_fault(hold_valid ? hold_access_fault : itlb_resp_access_fault),
		.icache_resp_valid_by_way(hold_valid ? hold_valid_by_way : icache_resp_valid_by_way),
		.icache_resp_tag_by_way(hold_valid ? hold_tag_by_way : icache_resp_tag_by_way),
		.icache_resp_instr_by_way(hold_valid ? hold_instr_by_way : icache_resp_instr_by_way)
	);

endmodule

`default_nettype wire

/* verilog/fetch_unit_wrapper.sv */
//--------------------------------------------------------------------
// top level around fetch_unit with one register stage on every port
// inputs arrive as next_*, outputs leave as last_*
//--------------------------------------------------------------------
`default_nettype none

module fetch_unit_wrapper (
	input logic CLK,
	input logic nRST,
	output logic last_itlb_req_valid,
	output fetch_types_pkg::vpn_t last_itlb_req_vpn,
	output fetch_types_pkg::asid_t last_itlb_req_asid,
	input logic next_itlb_resp_valid,
	input fetch_types_pkg::ppn_t next_itlb_resp_ppn,
	input logic next_itlb_resp_page_fault,
	input logic next_itlb_resp_access_fault,
	output logic last_icache_req_valid,
	output fetch_types_pkg::icache_index_t last_icache_req_index,
	output fetch_types_pkg::block_offset_t last_icache_req_block_offset,
	input logic [1:0] next_icache_resp_valid_by_way,
	input fetch_types_pkg::ppn_t [1:0] next_icache_resp_tag_by_way,
	input fetch_types_pkg::fetch_block_t [1:0] next_icache_resp_instr_by_way,
	output logic last_icache_resp_hit_valid,
	output logic last_icache_resp_hit_way,
	output logic last_icache_resp_miss_valid,
	output fetch_types_pkg::ppn_t last_icache_resp_miss_tag,
	output logic last_istream_valid,
	output fetch_types_pkg::parcel_mask_t last_istream_valid_by_parcel,
	output fetch_types_pkg::fetch_block_t last_istream_instr_block,
	output fetch_types_pkg::pc_t last_istream_after_pc,
	output logic last_istream_page_fault,
	output logic last_istream_access_fault,
	input logic next_istream_stall,
	input logic next_rob_restart_valid,
	input fetch_types_pkg::pc_t next_rob_restart_pc,
	input fetch_types_pkg::asid_t next_rob_restart_asid,
	input logic next_decode_restart_valid,
	input fetch_types_pkg::pc_t next_decode_restart_pc,
	input logic next_decode_trigger_wait_for_restart
);
	import fetch_types_pkg::*;

	// unit side of the port registers
	logic itlb_req_valid;
	vpn_t itlb_req_vpn;
	asid_t itlb_req_asid;
	logic itlb_resp_valid;
	ppn_t itlb_resp_ppn;
	logic itlb_resp_page_fault;
	logic itlb_resp_access_fault;
	logic icache_req_valid;
	icache_index_t icache_req_index;
	block_offset_t icache_req_block_offset;
	logic [1:0] icache_resp_valid_by_way;
	ppn_t [1:0] icache_resp_tag_by_way;
	fetch_block_t [1:0] icache_resp_instr_by_way;
	logic icache_resp_hit_valid;
	logic icache_resp_hit_way;
	logic icache_resp_miss_valid;
	ppn_t icache_resp_miss_tag;
	logic istream_valid;
	parcel_mask_t istream_valid_by_parcel;
	fetch_block_t istream_instr_block;
	pc_t istream_after_pc;
	logic istream_page_fault;
	logic istream_access_fault;
	logic istream_stall;
	logic rob_restart_valid;
	pc_t rob_restart_pc;
	asid_t rob_restart_asid;
	logic decode_restart_valid;
	pc_t decode_restart_pc;
	logic decode_trigger_wait_for_restart;

	fetch_unit u_fetch_unit (.*);

	//--------------------------------------------------------------------
	// port registers

	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			{last_itlb_req_valid, last_itlb_req_vpn, last_itlb_req_asid} <= '0;
			{itlb_resp_valid, itlb_resp_ppn, itlb_resp_page_fault, itlb_resp_access_fault} <= '0;
			{last_icache_req_valid, last_icache_req_index, last_icache_req_block_offset} <= '0;
			{icache_resp_valid_by_way, icache_resp_tag_by_way, icache_resp_instr_by_way} <= '0;
			{last_icache_resp_hit_valid, last_icache_resp_hit_way} <= '0;
			{last_icache_resp_miss_valid, last_icache_resp_miss_tag} <= '0;
			{last_istream_valid, last_istream_valid_by_parcel, last_istream_instr_block} <= '0;
			{last_istream_after_pc, last_istream_page_fault, last_istream_access_fault} <= '0;
			istream_stall <= 1'b0;
			{rob_restart_valid, rob_restart_pc, rob_restart_asid} <= '0;
			{decode_restart_valid, decode_restart_pc, decode_trigger_wait_for_restart} <= '0;
		end else begin
			// itlb
			last_itlb_req_valid <= itlb_req_valid;
			last_itlb_req_vpn <= itlb_req_vpn;
			last_itlb_req_asid <= itlb_req_asid;
			itlb_resp_valid <= next_itlb_resp_valid;
			itlb_resp_ppn <= next_itlb_resp_ppn;
			itlb_resp_page_fault <= next_itlb_resp_page_fault;
			itlb_resp_access_fault <= next_itlb_resp_access_fault;
			// icache
			last_icache_req_valid <= icache_req_valid;
			last_icache_req_index <= icache_req_index;
			last_icache_req_block_offset <= icache_req_block_offset;
			icache_resp_valid_by_way <= next_icache_resp_valid_by_way;
			icache_resp_tag_by_way <= next_icache_resp_tag_by_way;
			icache_resp_instr_by_way <= next_icache_resp_instr_by_way;
			last_icache_resp_hit_valid <= icache_resp_hit_valid;
			last_icache_resp_hit_way <= icache_resp_hit_way;
			last_icache_resp_miss_valid <= icache_resp_miss_valid;
			last_icache_resp_miss_tag <= icache_resp_miss_tag;
			// istream
			last_istream_valid <= istream_valid;
			last_istream_valid_by_parcel <= istream_valid_by_parcel;
			last_istream_instr_block <= istream_instr_block;
			last_istream_after_pc <= istream_after_pc;
			last_istream_page_fault <= istream_page_fault;
			last_istream_access_fault <= istream_access_fault;
			istream_stall <= next_istream_stall;
			// restarts
			rob_restart_valid <= next_rob_restart_valid;
			rob_restart_pc <= next_rob_restart_pc;
			rob_restart_asid <= next_rob_restart_asid;
			decode_restart_valid <= next_decode_restart_valid;
			decode_restart_pc <= next_decode_restart_pc;
			decode_trigger_wait_for_restart <= next_decode_trigger_wait_for_restart;
		end
	end

endmodule

`default_nettype wire

/* dv/fetch_unit_assertions.sv */
//----------------------------------------------------------------------
// request and istream protocol properties, bound into fetch_unit
//----------------------------------------------------------------------
`default_nettype none

module fetch_unit_assertions (
	input logic CLK,
	input logic nRST,
	input logic itlb_req_valid,
	input logic itlb_resp_valid,
	input logic rob_restart_valid,
	input logic decode_restart_valid,
	input logic istream_valid,
	input logic istream_stall,
	input fetch_types_pkg::parcel_mask_t istream_valid_by_parcel,
	input fetch_types_pkg::fetch_block_t istream_instr_block,
	input fetch_types_pkg::pc_t istream_after_pc,
	input logic icache_resp_hit_valid,
	input logic icache_resp_miss_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	int failures = 0;
	logic restart;
	logic outstanding;

	assign restart = rob_restart_valid | decode_restart_valid;

	// a request stays outstanding until its response or a restart
	always_ff @(posedge CLK or negedge nRST) begin
		if (!nRST) begin
			outstanding <= 1'b0;
		end else if (itlb_req_valid && !restart) begin
			outstanding <= 1'b1;
		end else if (itlb_resp_valid || restart) begin
			outstanding <= 1'b0;
		end
	end

	// one block in flight until its response or a restart
	single_request: assert property (@(posedge CLK) disable iff (!nRST)
		itlb_req_valid |-> !outstanding || itlb_resp_valid || restart)
	else begin
		failures++;
		$error("new fetch request while one is still in flight");
	end

	stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
		istream_valid && istream_stall |=> istream_valid && $stable(istream_instr_block) &&
			$stable(istream_valid_by_parcel) && $stable(istream_after_pc))
	else begin
		failures++;
		$error("istream entry changed while decode stalled");
	end

	// a miss comes with neither a hit nor a new istream entry
	hit_miss_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
		icache_resp_miss_valid |-> !icache_resp_hit_valid && !istream_valid)
	else begin
		failures++;
		$error("icache miss reported together with a hit or an istream entry");
	end

endmodule

bind fetch_unit fetch_unit_assertions u_assertions (.*);

`default_nettype wire

/* dv/fetch_unit_tb.sv */
//----------------------------------------------------------------------
// testbench for fetch_unit_wrapper with an ITLB/icache response model
// applies the row table in order and checks every request and block
//----------------------------------------------------------------------
`default_nettype none

`include "fetch_defs.svh"

module fetch_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import fetch_types_pkg::*;

	localparam int NROWS = 7;
	localparam int CYCLE_LIMIT = 40 * NROWS + 20;

	logic CLK;
	logic nRST;
	logic last_itlb_req_valid;
	vpn_t last_itlb_req_vpn;
	asid_t last_itlb_req_asid;
	logic next_itlb_resp_valid;
	ppn_t next_itlb_resp_ppn;
	logic next_itlb_resp_page_fault;
	logic next_itlb_resp_access_fault;
	logic last_icache_req_valid;
	icache_index_t last_icache_req_index;
	block_offset_t last_icache_req_block_offset;
	logic [1:0] next_icache_resp_valid_by_way;
	ppn_t [1:0] next_icache_resp_tag_by_way;
	fetch_block_t [1:0] next_icache_resp_instr_by_way;
	logic last_icache_resp_hit_valid;
	logic last_icache_resp_hit_way;
	logic last_icache_resp_miss_valid;
	ppn_t last_icache_resp_miss_tag;
	logic last_istream_valid;
	parcel_mask_t last_istream_valid_by_parcel;
	fetch_block_t last_istream_instr_block;
	pc_t last_istream_after_pc;
	logic last_istream_page_fault;
	logic last_istream_access_fault;
	logic next_istream_stall;
	logic next_rob_restart_valid;
	pc_t next_rob_restart_pc;
	asid_t next_rob_restart_asid;
	logic next_decode_restart_valid;
	pc_t next_decode_restart_pc;
	logic next_decode_trigger_wait_for_restart;

	//----------------------------------------------------------------------
	// row table
	// columns: restart pc, asid, hit way (2 = miss first), fault {access, page},
	// stall cycles after the first block, kill an earlier fetch first
	pc_t row_pc [NROWS] = '{32'h0000_1236, 32'h0004_5678, 32'h0012_3400,
		32'h0000_8004, 32'h0abc_d00a, 32'h0003_0010, 32'h0020_000c};
	asid_t row_asid [NROWS] = '{9'h011, 9'h011, 9'h022, 9'h022, 9'h1f0, 9'h005, 9'h0aa};
	int row_way [NROWS] = '{0, 1, 2, 0, 1, 0, 1};
	logic [1:0] row_fault [NROWS] = '{2'b00, 2'b00, 2'b00, 2'b00, 2'b01, 2'b10, 2'b00};
	int row_stall [NROWS] = '{0, 0, 0, 5, 0, 0, 0};
	bit row_kill [NROWS] = '{0, 0, 0, 0, 0, 0, 1};

	int errors = 0;
	int cycles = 0;
	asid_t cur_asid;
	logic stall_d1 = 1'b0;
	logic stall_d2 = 1'b0;
	logic [7:0] lfsr = 8'd8;

	fetch_unit_wrapper dut (.*);

	initial begin
		CLK = 1'b0;
		forever begin
			#20 CLK = ~CLK;
		end
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
	end

	initial begin
		wait (cycles >= CYCLE_LIMIT);
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Testbench failed");
		$finish;
	end

	//----------------------------------------------------------------------
	// model helpers

	// x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic next_random_bit();
		logic fb;
		fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
		lfsr = {lfsr[6:0], fb};
		return lfsr[0];
	endfunction

	function automatic ppn_t ppn_of(input vpn_t vpn);
		return ppn_t'(vpn ^ 20'h5a5a5);
	endfunction

	// words count up from the aligned pc, way 1 holds them inverted
	function automatic fetch_block_t instr_bytes(input pc_t pc, input logic way);
		fetch_block_t blk;
		pc_t word;
		for (int i = 0; i < `FETCH_BLOCK_BYTES / 4; i++) begin
			word = {pc[31:4], 4'h0} + pc_t'(4 * i);
			blk[32*i +: 32] = way ? ~word : word;
		end
		return blk;
	endfunction

	// way 2 gives a miss, neither tag matches the translated page
	task automatic drive_response(input pc_t pc, input int way, input logic [1:0] fault);
		ppn_t ppn;
		ppn = ppn_of(pc[31:12]);
		next_itlb_resp_valid = 1'b1;
		next_itlb_resp_ppn = ppn;
		next_itlb_resp_page_fault = fault[0];
		next_itlb_resp_access_fault = fault[1];
		next_icache_resp_valid_by_way = 2'b11;
		next_icache_resp_tag_by_way[0] = (way == 0) ? ppn : ppn ^ 20'h1;
		next_icache_resp_tag_by_way[1] = (way == 1) ? ppn : ppn ^ 20'h2;
		next_icache_resp_instr_by_way[0] = instr_bytes(pc, 1'b0);
		next_icache_resp_instr_by_way[1] = instr_bytes(pc, 1'b1);
	endtask

	//----------------------------------------------------------------------
	// compare tasks

	task automatic check_pc(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_block(input string name, input fetch_block_t got,
		input fetch_block_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_mask(input string name, input parcel_mask_t got,
		input parcel_mask_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_ppn(input string name, input ppn_t got, input ppn_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_asid(input string name, input asid_t got, input asid_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// pc bits 11:10 are not carried by the request
	task automatic check_request(input pc_t exp_pc);
		pc_t got;
		got = {last_itlb_req_vpn, 2'b00, last_icache_req_index, last_icache_req_block_offset};
		check_pc("last_itlb_req_vpn/last_icache_req_index/offset", got, exp_pc & 32'hffff_f3ff);
		check_asid("last_itlb_req_asid", last_itlb_req_asid, cur_asid);
		check_flag("last_icache_req_valid", last_icache_req_valid, 1'b1);
	endtask

	task automatic wait_request(input pc_t exp_pc);
		@(negedge CLK);
		while (!last_itlb_req_valid) begin
			@(negedge CLK);
		end
		check_request(exp_pc);
	endtask

	//----------------------------------------------------------------------
	// one table row: restart, answer requests, collect blocks in order

	task automatic run_row(input int r);
		pc_t req_pc;
		pc_t out_q[$];
		pc_t head;
		logic exp_way;
		int delay;
		int blocks_given;
		int wanted;
		int stall_left;
		int quiet;
		int hits_exp;
		int hits_seen;
		int misses_seen;
		bit arm;
		bit missed;
		bit seen_next;
		bit done;
		req_pc = row_pc[r];
		exp_way = (row_way[r] == 1);
		delay = -1;
		blocks_given = 0;
		wanted = (row_fault[r] != 2'b00) ? 1 : 2;
		stall_left = row_stall[r];
		quiet = 0;
		hits_exp = 0;
		hits_seen = 0;
		misses_seen = 0;
		arm = 1'b0;
		missed = 1'b0;
		seen_next = 1'b0;
		done = 1'b0;
		@(posedge CLK);
		#2;
		next_rob_restart_valid = 1'b1;
		next_rob_restart_asid = row_asid[r];
		cur_asid = row_asid[r];
		if (row_kill[r]) begin
			// fetch another page first, its late response must vanish
			next_rob_restart_pc = row_pc[r] + 32'h0001_0000;
			@(posedge CLK);
			#2;
			next_rob_restart_valid = 1'b0;
			wait_request(row_pc[r] + 32'h0001_0000);
			@(posedge CLK);
			#2;
			next_decode_restart_valid = 1'b1;
			next_decode_restart_pc = row_pc[r];
			@(posedge CLK);
			#2;
			next_decode_restart_valid = 1'b0;
			drive_response(row_pc[r] + 32'h0001_0000, 0, 2'b00);
		end else begin
			next_rob_restart_pc = row_pc[r];
		end
		while (!done) begin
			@(negedge CLK);
			if (last_itlb_req_valid) begin
				if (row_fault[r] != 2'b00 && blocks_given != 0) begin
					errors++;
					$display("a request was issued after a fault and before a restart");
				end else begin
					check_request(req_pc);
					if (blocks_given == wanted) begin
						seen_next = 1'b1;
					end else begin
						delay = {next_random_bit(), next_random_bit()};
					end
				end
			end
			if (last_icache_resp_miss_valid) begin
				misses_seen++;
				check_ppn("last_icache_resp_miss_tag", last_icache_resp_miss_tag,
					ppn_of(req_pc[31:12]));
				check_flag("last_icache_resp_hit_valid", last_icache_resp_hit_valid, 1'b0);
			end
			if (last_icache_resp_hit_valid) begin
				hits_seen++;
				check_flag("last_icache_resp_hit_way", last_icache_resp_hit_way, exp_way);
			end
			// a block counts once, in the cycle decode takes it
			if (last_istream_valid && !stall_d2) begin
				if (out_q.size() == 0) begin
					errors++;
					$display("an istream block appeared when none was expected");
				end else begin
					head = out_q.pop_front();
					check_block("last_istream_instr_block", last_istream_instr_block,
						(row_fault[r] != 2'b00) ? fetch_block_t'(0) : instr_bytes(head, exp_way));
					check_mask("last_istream_valid_by_parcel", last_istream_valid_by_parcel,
						parcel_mask_t'(8'hff << head[3:1]));
					check_pc("last_istream_after_pc", last_istream_after_pc,
						{head[31:4], 4'h0} + pc_t'(`FETCH_BLOCK_BYTES));
					check_flag("last_istream_page_fault", last_istream_page_fault,
						row_fault[r][0]);
					check_flag("last_istream_access_fault", last_istream_access_fault,
						row_fault[r][1]);
				end
			end
			quiet = (blocks_given == wanted && out_q.size() == 0) ? quiet + 1 : 0;
			done = blocks_given == wanted && out_q.size() == 0 &&
				((row_fault[r] != 2'b00) ? quiet >= 8 : seen_next);
			@(posedge CLK);
			#2;
			next_itlb_resp_valid = 1'b0;
			next_rob_restart_valid = 1'b0;
			next_decode_restart_valid = 1'b0;
			stall_d2 = stall_d1;
			stall_d1 = next_istream_stall;
			if (arm) begin
				next_istream_stall = (stall_left > 0);
				if (stall_left > 0) begin
					stall_left--;
				end
			end
			if (delay == 0) begin
				delay = -1;
				if (row_way[r] == 2 && !missed) begin
					missed = 1'b1;
					drive_response(req_pc, 2, 2'b00);
				end else begin
					drive_response(req_pc, int'(exp_way), row_fault[r]);
					out_q.push_back(req_pc);
					blocks_given++;
					arm = arm || (row_stall[r] > 0);
					if (row_fault[r] == 2'b00) begin
						hits_exp++;
						req_pc = {req_pc[31:4], 4'h0} + pc_t'(`FETCH_BLOCK_BYTES);
					end
				end
			end else if (delay > 0) begin
				delay--;
			end
		end
		if (misses_seen != ((row_way[r] == 2) ? 1 : 0)) begin
			errors++;
			$display("row %0d reported %0d icache misses, expected %0d", r, misses_seen,
				(row_way[r] == 2) ? 1 : 0);
		end
		if (hits_seen != hits_exp) begin
			errors++;
			$display("row %0d reported %0d icache hits, expected %0d", r, hits_seen, hits_exp);
		end
	endtask

	initial begin
		int assert_fails;
		nRST = 1'b0;
		next_itlb_resp_valid = 1'b0;
		next_itlb_resp_ppn = '0;
		next_itlb_resp_page_fault = 1'b0;
		next_itlb_resp_access_fault = 1'b0;
		next_icache_resp_valid_by_way = '0;
		next_icache_resp_tag_by_way = '0;
		next_icache_resp_instr_by_way = '0;
		next_istream_stall = 1'b0;
		next_rob_restart_valid = 1'b0;
		next_rob_restart_pc = '0;
		next_rob_restart_asid = '0;
		next_decode_restart_valid = 1'b0;
		next_decode_restart_pc = '0;
		next_decode_trigger_wait_for_restart = 1'b0;
		cur_asid = '0;
		repeat (4) @(posedge CLK);
		#2;
		nRST = 1'b1;
		// idle after reset, nothing moves before a restart
		repeat (6) begin
			@(negedge CLK);
			check_flag("last_itlb_req_valid", last_itlb_req_valid, 1'b0);
			check_flag("last_icache_req_valid", last_icache_req_valid, 1'b0);
			check_flag("last_istream_valid", last_istream_valid, 1'b0);
			check_flag("last_icache_resp_hit_valid", last_icache_resp_hit_valid, 1'b0);
			check_flag("last_icache_resp_miss_valid", last_icache_resp_miss_valid, 1'b0);
		end
		for (int r = 0; r < NROWS; r++) begin
			run_row(r);
		end
		assert_fails = dut.u_fetch_unit.u_assertions.failures;
		$display("errors: %0d, assertion failures: %0d", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+common
common/fetch_types_pkg.sv
fetch_unit/fetch_pc_gen.sv
fetch_unit/fetch_tag_check.sv
fetch_unit/fetch_unit.sv
verilog/fetch_unit_wrapper.sv
dv/fetch_unit_assertions.sv
dv/fetch_unit_tb.sv

/* Bender.yml */
package:
  name: fetch_unit

sources:
  - include_dirs:
      - common
    files:
      - common/fetch_types_pkg.sv
      - fetch_unit/fetch_pc_gen.sv
      - fetch_unit/fetch_tag_check.sv
      - fetch_unit/fetch_unit.sv
      - verilog/fetch_unit_wrapper.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/fetch_unit_assertions.sv
      - dv/fetch_unit_tb.sv
